// File: umi_pkg.sv
// umi_pkg: packet widths, opcodes, command word views, packet field offsets
`default_nettype none

package umi_pkg;

   localparam int unsigned umi_pw = 256; // full packet
   localparam int unsigned umi_aw = 64;  // address width
   localparam int unsigned umi_dw = 64;  // one data beat

   // packet field offsets, top 32 bits stay zero
   localparam int unsigned umi_cmd_lsb  = 0;
   localparam int unsigned umi_dst_lsb  = 32;
   localparam int unsigned umi_src_lsb  = 96;
   localparam int unsigned umi_data_lsb = 160;

   typedef enum logic [7:0] {
      umi_invalid          = 8'h00,
      umi_req_read         = 8'h01,
      umi_req_write_posted = 8'h02,
      umi_req_write_ack    = 8'h03,
      umi_req_write_signal = 8'h04, // not handled here
      umi_req_write_stream = 8'h05, // not handled here
      umi_resp_write       = 8'h06,
      umi_resp_read        = 8'h07,
      umi_req_atomic       = 8'h08
   } umi_opcode_e;

   // read, write and response view
   typedef struct packed {
      logic [19:0] user;
      logic [3:0]  size;   // beats minus one
      logic [7:0]  opcode;
   } umi_xfer_t;

   // atomic view, same word
   typedef struct packed {
      logic [19:0] user;
      logic [3:0]  op;     // atomic operation code
      logic [7:0]  opcode;
   } umi_atomic_t;

   // bits 11..8 mean size or atomic op depending on opcode
   typedef union packed {
      umi_xfer_t   xfer;
      umi_atomic_t atomic;
   } umi_cmd_u;

endpackage

`default_nettype wire

// File: umi_agent_pkg.sv
// umi_agent_pkg: atomic operation codes and memory word type for the endpoint
`default_nettype none

package umi_agent_pkg;

   // codes 7..15 are rejected by the decoder
   typedef enum logic [3:0] {
      atomic_swap = 4'd0,
      atomic_add  = 4'd1,
      atomic_and  = 4'd2,
      atomic_or   = 4'd3,
      atomic_xor  = 4'd4,
      atomic_min  = 4'd5, // signed
      atomic_max  = 4'd6  // signed
   } atomic_op_e;

   typedef logic [63:0] mem_word_t; // one memory word, one beat

endpackage

`default_nettype wire

// File: umi_cmd_if.sv
// umi_cmd_if: decoded request from unpacker to control, with unpack and ctrl modports
`timescale 1ns/1ps
`default_nettype none

interface umi_cmd_if;
   import umi_pkg::*;
   import umi_agent_pkg::*;

   logic              valid;     // request present this cycle
   logic              is_read;
   logic              is_write;  // posted or acked
   logic              write_ack; // response wanted
   logic              is_atomic;
   logic              invalid;   // drop and flag
   atomic_op_e        atomic_op;
   logic [3:0]        size;
   logic [19:0]       user;
   logic [umi_aw-1:0] dstaddr;
   logic [umi_aw-1:0] srcaddr;
   logic [umi_dw-1:0] data;

   modport unpack (
      output valid, is_read, is_write, write_ack, is_atomic, invalid,
      output atomic_op, size, user, dstaddr, srcaddr, data
   );

   modport ctrl (
      input valid, is_read, is_write, write_ack, is_atomic, invalid,
      input atomic_op, size, user, dstaddr, srcaddr, data
   );

endinterface

`default_nettype wire

// File: umi_decode.sv
// umi_decode: command word classifier into kind flags, atomic op and size
`timescale 1ns/1ps
`default_nettype none

module umi_decode (
   input  umi_pkg::umi_cmd_u         cmd,
   output logic                      is_read,
   output logic                      is_write,
   output logic                      write_ack,
   output logic                      is_atomic,
   output logic                      invalid,
   output umi_agent_pkg::atomic_op_e atomic_op,
   output logic [3:0]                size
);
   import umi_pkg::*;
   import umi_agent_pkg::*;

   logic op_ok; // atomic code inside the dense 0..6 range

   assign op_ok = (cmd.atomic.op <= atomic_max);

   always_comb begin
      is_read   = 1'b0;
      is_write  = 1'b0;
      write_ack = 1'b0;
      is_atomic = 1'b0;
      invalid   = 1'b0;
      atomic_op = atomic_swap;   // don't care unless atomic
      size      = cmd.xfer.size; // transfer view by default
      case (cmd.xfer.opcode)
         umi_req_read:         is_read = 1'b1;
         umi_req_write_posted: is_write = 1'b1;
         umi_req_write_ack: begin
            is_write  = 1'b1;
            write_ack = 1'b1;
         end
         umi_req_atomic: begin
            size = 4'd0; // field holds the op here
            if (op_ok) begin
               is_atomic = 1'b1;
               atomic_op = atomic_op_e'(cmd.atomic.op);
            end else begin
               invalid = 1'b1; // unknown atomic code
            end
         end
         // signal, stream, responses and garbage all land here
         default: invalid = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

// File: umi_unpack.sv
// umi_unpack: request packet field splitter driving the command interface
`timescale 1ns/1ps
`default_nettype none

module umi_unpack (
   input  logic                       packet_valid,
   input  logic [umi_pkg::umi_pw-1:0] packet_in,
   umi_cmd_if.unpack                  cmd
);
   import umi_pkg::*;

   umi_cmd_u cmd_word; // low 32 bits of the packet

   assign cmd_word = packet_in[umi_cmd_lsb +: 32];

   // no handshake, valid goes straight through
   assign cmd.valid = packet_valid;

   umi_decode u_decode (
      .cmd       (cmd_word),
      .is_read   (cmd.is_read),
      .is_write  (cmd.is_write),
      .write_ack (cmd.write_ack),
      .is_atomic (cmd.is_atomic),
      .invalid   (cmd.invalid),
      .atomic_op (cmd.atomic_op),
      .size      (cmd.size)
   );

   assign cmd.user = cmd_word.xfer.user; // same bits in both views

   // fixed layout, single 64-bit beat
   assign cmd.dstaddr = packet_in[umi_dst_lsb +: umi_aw];
   assign cmd.srcaddr = packet_in[umi_src_lsb +: umi_aw];
   assign cmd.data    = packet_in[umi_data_lsb +: umi_dw];

endmodule

`default_nettype wire

// File: umi_pack.sv
// umi_pack: response packet assembler in the shared packet layout
`timescale 1ns/1ps
`default_nettype none

module umi_pack (
   input  umi_pkg::umi_opcode_e       opcode,
   input  logic [3:0]                 size,
   input  logic [19:0]                user,
   input  logic [umi_pkg::umi_aw-1:0] dstaddr,
   input  logic [umi_pkg::umi_aw-1:0] srcaddr,
   input  umi_agent_pkg::mem_word_t   data,
   output logic [umi_pkg::umi_pw-1:0] packet
);
   import umi_pkg::*;

   umi_cmd_u cmd_word;

   // responses always use the transfer view
   always_comb begin
      cmd_word.xfer.opcode = opcode;
      cmd_word.xfer.size   = size;
      cmd_word.xfer.user   = user;
   end

   always_comb begin
      packet = '0; // top word stays zero
      packet[umi_cmd_lsb +: 32]      = cmd_word;
      packet[umi_dst_lsb +: umi_aw]  = dstaddr;
      packet[umi_src_lsb +: umi_aw]  = srcaddr;
      packet[umi_data_lsb +: umi_dw] = data;
   end

endmodule

`default_nettype wire

// File: umi_atomic_alu.sv
// umi_atomic_alu: combinational read-modify-write operators for atomics
`timescale 1ns/1ps
`default_nettype none

module umi_atomic_alu (
   input  umi_agent_pkg::atomic_op_e op,
   input  umi_agent_pkg::mem_word_t  old_val,
   input  umi_agent_pkg::mem_word_t  operand,
   output umi_agent_pkg::mem_word_t  new_val
);
   import umi_agent_pkg::*;

   logic old_lt; // old < operand, two's complement

   assign old_lt = ($signed(old_val) < $signed(operand));

   always_comb begin
      case (op)
         atomic_swap: new_val = operand;
         atomic_add:  new_val = old_val + operand; // wraps at 64 bits
         atomic_and:  new_val = old_val & operand;
         atomic_or:   new_val = old_val | operand;
         atomic_xor:  new_val = old_val ^ operand;
         atomic_min:  new_val = old_lt ? old_val : operand;
         atomic_max:  new_val = old_lt ? operand : old_val;
         default:     new_val = old_val; // decoder never lets these through
      endcase
   end

endmodule

`default_nettype wire

// File: umi_mem_array.sv
// umi_mem_array: word memory, one write port, one registered read port
`timescale 1ns/1ps
`default_nettype none

module umi_mem_array #(
   parameter int MEM_DEPTH = 256
) (
   input  logic                         clk,
   input  logic                         we,
   input  logic [$clog2(MEM_DEPTH)-1:0] waddr,
   input  logic [$clog2(MEM_DEPTH)-1:0] raddr,
   input  umi_agent_pkg::mem_word_t     wdata,
   input  logic                         re,
   output umi_agent_pkg::mem_word_t     rdata
);
   import umi_agent_pkg::*;

   mem_word_t mem [MEM_DEPTH];

   // read before write, same-address hits are fixed up in the control
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
      if (re) begin
         rdata <= mem[raddr];
      end
   end

endmodule

`default_nettype wire

// File: umi_mem_agent_ctrl.sv
// umi_mem_agent_ctrl: stage-2 register, write port arbitration, write buffer, bypass, outputs
`timescale 1ns/1ps
`default_nettype none

module umi_mem_agent_ctrl #(
   parameter int MEM_DEPTH = 256
) (
   input  logic                         clk,
   input  logic                         rst,
   umi_cmd_if.ctrl                      cmd,
   output logic                         mem_we,
   output logic                         mem_re,
   output logic [$clog2(MEM_DEPTH)-1:0] mem_waddr,
   output logic [$clog2(MEM_DEPTH)-1:0] mem_raddr,
   output umi_agent_pkg::mem_word_t     mem_wdata,
   input  umi_agent_pkg::mem_word_t     mem_rdata,
   output umi_agent_pkg::atomic_op_e    alu_op,
   output umi_agent_pkg::mem_word_t     alu_old,
   output umi_agent_pkg::mem_word_t     alu_operand,
   input  umi_agent_pkg::mem_word_t     alu_new,
   output umi_pkg::umi_opcode_e         rsp_opcode,
   output logic [3:0]                   rsp_size,
   output logic [19:0]                  rsp_user,
   output logic [63:0]                  rsp_dstaddr,
   output logic [63:0]                  rsp_srcaddr,
   output umi_agent_pkg::mem_word_t     rsp_data,
   input  logic [255:0]                 rsp_packet,
   output logic                         resp_valid,
   output logic                         cmd_error,
   output logic [255:0]                 resp_packet
);
   import umi_pkg::*;
   import umi_agent_pkg::*;

   localparam int addr_w = $clog2(MEM_DEPTH);

   logic [umi_aw-1:0] s1_word;  // byte address / 8, wrapped
   logic [addr_w-1:0] s1_addr;
   logic              s1_wr;    // write wants the port
   logic              s1_rd;    // read or atomic needs old data
   logic              s1_to_buf;

   logic              s2_valid;
   logic              s2_read;
   logic              s2_write_ack;
   logic              s2_atomic;
   logic              s2_invalid;
   atomic_op_e        s2_op;
   logic [3:0]        s2_size;
   logic [19:0]       s2_user;
   logic [umi_aw-1:0] s2_dstaddr;
   logic [umi_aw-1:0] s2_srcaddr;
   mem_word_t         s2_operand;
   logic [addr_w-1:0] s2_addr;
   logic              s2_wb;    // atomic write-back this cycle
   mem_word_t         s2_old;   // data as seen in request order

   logic              byp_hit;
   mem_word_t         byp_data;
   logic              wbuf_valid;
   logic [addr_w-1:0] wbuf_addr;
   mem_word_t         wbuf_data;

   assign s1_word = (cmd.dstaddr >> 3) % MEM_DEPTH;
   assign s1_addr = s1_word[addr_w-1:0];
   assign s1_wr   = cmd.valid & cmd.is_write;
   assign s1_rd   = cmd.valid & (cmd.is_read | cmd.is_atomic);

   assign mem_re    = s1_rd; // data back in stage 2
   assign mem_raddr = s1_addr;

   assign s2_wb = s2_valid & s2_atomic;

   // port order: atomic write-back, then buffered write, then new write
   // write-back and a full buffer never meet since a buffered write sits in s2
   always_comb begin
      mem_we    = 1'b0;
      mem_waddr = s1_addr;
      mem_wdata = cmd.data;
      if (s2_wb) begin
         mem_we    = 1'b1;
         mem_waddr = s2_addr;
         mem_wdata = alu_new;
      end else if (wbuf_valid) begin
         mem_we    = 1'b1;
         mem_waddr = wbuf_addr;
         mem_wdata = wbuf_data;
      end else if (s1_wr) begin
         mem_we = 1'b1;
      end
   end

   assign s1_to_buf = s1_wr & (s2_wb | wbuf_valid); // port busy, park it

   always_ff @(posedge clk) begin
      if (rst) begin
         wbuf_valid <= 1'b0;
         s2_valid   <= 1'b0;
         byp_hit    <= 1'b0;
         resp_valid <= 1'b0;
         cmd_error  <= 1'b0;
      end else begin
         wbuf_valid <= s1_to_buf; // old entry drains this cycle anyway
         s2_valid   <= cmd.valid;
         // whatever hits the port now is newer than the array read
         byp_hit    <= s1_rd & mem_we & (mem_waddr == s1_addr);
         resp_valid <= s2_valid & (s2_read | s2_write_ack | s2_atomic);
         cmd_error  <= s2_valid & s2_invalid;
      end
   end

   always_ff @(posedge clk) begin
      if (s1_to_buf) begin
         wbuf_addr <= s1_addr;
         wbuf_data <= cmd.data;
      end
      byp_data     <= mem_wdata;
      s2_read      <= cmd.is_read;
      s2_write_ack <= cmd.write_ack;
      s2_atomic    <= cmd.is_atomic;
      s2_invalid   <= cmd.invalid;
      s2_op        <= cmd.atomic_op;
      s2_size      <= cmd.size;
      s2_user      <= cmd.user;
      s2_dstaddr   <= cmd.dstaddr;
      s2_srcaddr   <= cmd.srcaddr;
      s2_operand   <= cmd.data;
      s2_addr      <= s1_addr;
   end

   assign s2_old = byp_hit ? byp_data : mem_rdata;

   assign alu_op      = s2_op;
   assign alu_old     = s2_old;
   assign alu_operand = s2_operand;

   // response goes back where it came from
   assign rsp_opcode  = s2_write_ack ? umi_resp_write : umi_resp_read;
   assign rsp_size    = s2_size;
   assign rsp_user    = s2_user;
   assign rsp_dstaddr = s2_srcaddr;
   assign rsp_srcaddr = s2_dstaddr;
   assign rsp_data    = s2_write_ack ? '0 : s2_old; // atomics return old value

   always_ff @(posedge clk) begin
      if (s2_valid) begin
         resp_packet <= rsp_packet;
      end
   end

endmodule

`default_nettype wire

// File: umi_mem_agent.sv
// umi_mem_agent: memory endpoint top, unpack, control, memory, atomic ALU, pack
`timescale 1ns/1ps
`default_nettype none

module umi_mem_agent #(
   parameter int MEM_DEPTH = 256
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       packet_valid,
   input  logic [umi_pkg::umi_pw-1:0] packet_in,
   output logic                       resp_valid,
   output logic [umi_pkg::umi_pw-1:0] resp_packet,
   output logic                       cmd_error
);
   import umi_pkg::*;
   import umi_agent_pkg::*;

   localparam int addr_w = $clog2(MEM_DEPTH);

   umi_cmd_if cmd_if ();

   logic              mem_we;
   logic              mem_re;
   logic [addr_w-1:0] mem_waddr;
   logic [addr_w-1:0] mem_raddr;
   mem_word_t         mem_wdata;
   mem_word_t         mem_rdata;
   atomic_op_e        alu_op;
   mem_word_t         alu_old;
   mem_word_t         alu_operand;
   mem_word_t         alu_new;
   umi_opcode_e       rsp_opcode;
   logic [3:0]        rsp_size;
   logic [19:0]       rsp_user;
   logic [umi_aw-1:0] rsp_dstaddr;
   logic [umi_aw-1:0] rsp_srcaddr;
   mem_word_t         rsp_data;
   logic [umi_pw-1:0] rsp_packet; // combinational, registered in ctrl

   umi_unpack u_unpack (
      .packet_valid (packet_valid),
      .packet_in    (packet_in),
      .cmd          (cmd_if)
   );

   umi_mem_agent_ctrl #(.MEM_DEPTH(MEM_DEPTH)) u_ctrl (
      .clk         (clk),
      .rst         (rst),
      .cmd         (cmd_if),
      .mem_we      (mem_we),
      .mem_re      (mem_re),
      .mem_waddr   (mem_waddr),
      .mem_raddr   (mem_raddr),
      .mem_wdata   (mem_wdata),
      .mem_rdata   (mem_rdata),
      .alu_op      (alu_op),
      .alu_old     (alu_old),
      .alu_operand (alu_operand),
      .alu_new     (alu_new),
      .rsp_opcode  (rsp_opcode),
      .rsp_size    (rsp_size),
      .rsp_user    (rsp_user),
      .rsp_dstaddr (rsp_dstaddr),
      .rsp_srcaddr (rsp_srcaddr),
      .rsp_data    (rsp_data),
      .rsp_packet  (rsp_packet),
      .resp_valid  (resp_valid),
      .cmd_error   (cmd_error),
      .resp_packet (resp_packet)
   );

   umi_mem_array #(.MEM_DEPTH(MEM_DEPTH)) u_mem (
      .clk   (clk),
      .we    (mem_we),
      .waddr (mem_waddr),
      .raddr (mem_raddr),
      .wdata (mem_wdata),
      .re    (mem_re),
      .rdata (mem_rdata)
   );

   umi_atomic_alu u_alu (
      .op      (alu_op),
      .old_val (alu_old),
      .operand (alu_operand),
      .new_val (alu_new)
   );

   umi_pack u_pack (
      .opcode  (rsp_opcode),
      .size    (rsp_size),
      .user    (rsp_user),
      .dstaddr (rsp_dstaddr),
      .srcaddr (rsp_srcaddr),
      .data    (rsp_data),
      .packet  (rsp_packet)
   );

endmodule

`default_nettype wire

// File: tb_umi_mem_agent.sv
// table-driven testbench with reference memory model and response scoreboard
`timescale 1ns/1ps
`default_nettype none

module tb_umi_mem_agent;
   import umi_pkg::*;
   import umi_agent_pkg::*;

   localparam int MEM_DEPTH   = 256;
   localparam int max_rows    = 48;
   localparam int drain_limit = 20; // cycles to wait for the last responses
   localparam int out_none    = 0;  // posted write gets no response
   localparam int out_resp    = 1;
   localparam int out_err     = 2;

   localparam logic [7:0] op_none   = umi_invalid;
   localparam logic [7:0] op_read   = umi_req_read;
   localparam logic [7:0] op_post   = umi_req_write_posted;
   localparam logic [7:0] op_ack    = umi_req_write_ack;
   localparam logic [7:0] op_stream = umi_req_write_stream;
   localparam logic [7:0] op_amo    = umi_req_atomic;

   logic              clk;
   logic              rst;
   logic              packet_valid;
   logic [umi_pw-1:0] packet_in;
   logic              resp_valid;
   logic [umi_pw-1:0] resp_packet;
   logic              cmd_error;

   // stimulus table
   int          tbl_test [max_rows];
   logic [7:0]  tbl_opc  [max_rows];
   logic [3:0]  tbl_fld  [max_rows]; // size or atomic op
   logic [63:0] tbl_addr [max_rows];
   logic [63:0] tbl_data [max_rows];
   bit          tbl_gap  [max_rows]; // idle cycle after the row
   bit          tbl_rnd  [max_rows]; // data from $random instead
   int          tbl_out  [max_rows];
   int          n_rows;

   mem_word_t    ref_mem [int];  // reference model keyed by word index
   int           exp_due [$];    // cycle the outcome shows up
   int           exp_kind [$];
   logic [255:0] exp_pkt [$];

   int     cycle;
   int     error_count;
   int     passed;
   int     failed;
   int     n_expected;   // outcomes the table asks for
   int     n_seen;       // strobes the DUT raised
   integer seed;
   int     i;
   int     errs_before;

   umi_mem_agent #(.MEM_DEPTH(MEM_DEPTH)) u_umi_mem_agent (
      .clk          (clk),
      .rst          (rst),
      .packet_valid (packet_valid),
      .packet_in    (packet_in),
      .resp_valid   (resp_valid),
      .resp_packet  (resp_packet),
      .cmd_error    (cmd_error)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [255:0] actual,
                              input logic [255:0] expected);
      if (actual !== expected) begin
         error_count++;
         $display("ERROR %s: got 0x%0h, expected 0x%0h (cycle %0d)", name, actual, expected,
                  cycle);
      end
   endtask

   // fields from low to high are cmd, dst, src and data
   function automatic logic [255:0] make_packet(input logic [7:0] opc, input logic [3:0] fld,
                                                input logic [19:0] user,
                                                input logic [63:0] dst, input logic [63:0] src,
                                                input logic [63:0] data);
      logic [255:0] pkt;
      pkt            = '0;
      pkt[31:0]      = {user, fld, opc};
      pkt[95:32]     = dst;
      pkt[159:96]    = src;
      pkt[223:160]   = data;
      return pkt;
   endfunction

   function automatic int word_index(input logic [63:0] addr);
      return int'((addr >> 3) % MEM_DEPTH); // 8-byte words wrapping at the depth
   endfunction

   function automatic mem_word_t atomic_result(input logic [3:0] op, input mem_word_t old,
                                               input mem_word_t operand);
      case (op)
         4'd0:    return operand;
         4'd1:    return old + operand;
         4'd2:    return old & operand;
         4'd3:    return old | operand;
         4'd4:    return old ^ operand;
         4'd5:    return ($signed(operand) < $signed(old)) ? operand : old;
         4'd6:    return ($signed(operand) > $signed(old)) ? operand : old;
         default: return old;
      endcase
   endfunction

   task automatic add_row(input int test, input logic [7:0] opc, input logic [3:0] fld,
                          input logic [63:0] addr, input logic [63:0] data,
                          input bit gap, input bit rnd, input int out);
      tbl_test[n_rows] = test;
      tbl_opc[n_rows]  = opc;
      tbl_fld[n_rows]  = fld;
      tbl_addr[n_rows] = addr;
      tbl_data[n_rows] = data;
      tbl_gap[n_rows]  = gap;
      tbl_rnd[n_rows]  = rnd;
      tbl_out[n_rows]  = out;
      n_rows++;
   endtask

   task automatic build_table();
      n_rows = 0;
      // write then read with an aliased address at the end
      add_row(1, op_post, 4'd0, 64'h00, 64'h1111_2222_3333_4444, 0, 0, out_none);
      add_row(1, op_post, 4'd0, 64'h08, 64'h0, 0, 1, out_none);
      add_row(1, op_post, 4'd0, 64'h10, 64'h0, 1, 1, out_none);
      add_row(1, op_read, 4'd0, 64'h00, 64'h0, 0, 0, out_resp);
      add_row(1, op_read, 4'd3, 64'h08, 64'h0, 0, 0, out_resp);
      add_row(1, op_read, 4'd1, 64'h10, 64'h0, 1, 0, out_resp);
      add_row(1, op_post, 4'd0, 64'h1_0000_0018, 64'h0, 1, 1, out_none); // wraps to word 3
      add_row(1, op_read, 4'd0, 64'h18, 64'h0, 1, 0, out_resp);
      // acked writes
      add_row(2, op_ack, 4'd2, 64'h20, 64'h0, 0, 1, out_resp);
      add_row(2, op_ack, 4'hf, 64'h28, 64'hdead_beef_0bad_f00d, 1, 0, out_resp);
      add_row(2, op_read, 4'd0, 64'h20, 64'h0, 1, 0, out_resp);
      // every atomic op chained on one word
      add_row(3, op_post, 4'd0, 64'h40, 64'hff, 1, 0, out_none);
      add_row(3, op_amo, atomic_add, 64'h40, 64'hffff_ffff_ffff_ff10, 1, 0, out_resp);
      add_row(3, op_amo, atomic_and, 64'h40, 64'h0, 1, 1, out_resp);
      add_row(3, op_amo, atomic_or, 64'h40, 64'h0, 1, 1, out_resp);
      add_row(3, op_amo, atomic_xor, 64'h40, 64'h0, 1, 1, out_resp);
      add_row(3, op_amo, atomic_swap, 64'h40, 64'h5, 1, 0, out_resp);
      add_row(3, op_amo, atomic_min, 64'h40, 64'hffff_ffff_ffff_fffd, 1, 0, out_resp); // -3
      add_row(3, op_amo, atomic_max, 64'h40, 64'h2, 1, 0, out_resp);
      add_row(3, op_read, 4'd0, 64'h40, 64'h0, 1, 0, out_resp);
      // back to back on one word without gaps
      add_row(4, op_post, 4'd0, 64'h80, 64'd100, 0, 0, out_none);
      add_row(4, op_amo, atomic_add, 64'h80, 64'd1, 0, 0, out_resp);
      add_row(4, op_read, 4'd0, 64'h80, 64'h0, 0, 0, out_resp);       // wb bypass
      add_row(4, op_amo, atomic_add, 64'h80, 64'd2, 0, 0, out_resp);
      add_row(4, op_post, 4'd0, 64'h80, 64'h0, 0, 1, out_none);      // parked in buffer
      add_row(4, op_read, 4'd0, 64'h80, 64'h0, 0, 0, out_resp);       // buffer bypass
      add_row(4, op_amo, atomic_xor, 64'h80, 64'h0, 0, 1, out_resp);
      add_row(4, op_amo, atomic_max, 64'h80, 64'h0, 0, 1, out_resp);  // atomic on atomic
      add_row(4, op_ack, 4'd1, 64'h80, 64'h0, 0, 1, out_resp);
      add_row(4, op_post, 4'd0, 64'h80, 64'h0, 0, 1, out_none);      // buffer refilled
      add_row(4, op_amo, atomic_swap, 64'h80, 64'h0, 0, 1, out_resp);
      add_row(4, op_read, 4'd0, 64'h80, 64'h0, 1, 0, out_resp);
      // dropped commands leave the word alone
      add_row(5, op_post, 4'd0, 64'hc0, 64'h5a5a_5a5a_a5a5_a5a5, 0, 0, out_none);
      add_row(5, op_none, 4'd0, 64'hc0, 64'h0, 0, 1, out_err);
      add_row(5, op_stream, 4'd0, 64'hc0, 64'h0, 0, 1, out_err);
      add_row(5, op_amo, 4'd9, 64'hc0, 64'h0, 0, 1, out_err);
      add_row(5, op_read, 4'd0, 64'hc0, 64'h0, 1, 0, out_resp);
   endtask

   task automatic check_outputs();
      int           kind;
      logic [255:0] pkt;
      kind = out_none;
      pkt  = '0;
      if (exp_due.size() > 0 && exp_due[0] == cycle) begin
         exp_due.delete(0);
         kind = exp_kind.pop_front();
         pkt  = exp_pkt.pop_front();
      end
      if (resp_valid === 1'b1) begin
         n_seen++;
      end
      if (cmd_error === 1'b1) begin
         n_seen++;
      end
      check_value("resp_valid", resp_valid, kind == out_resp);
      check_value("cmd_error", cmd_error, kind == out_err);
      if (kind == out_resp && resp_valid === 1'b1) begin
         check_value("resp_packet.cmd", resp_packet[31:0], pkt[31:0]);
         check_value("resp_packet.dstaddr", resp_packet[95:32], pkt[95:32]);
         check_value("resp_packet.srcaddr", resp_packet[159:96], pkt[159:96]);
         check_value("resp_packet.data", resp_packet[223:160], pkt[223:160]);
         check_value("resp_packet.unused", resp_packet[255:224], pkt[255:224]);
      end
   endtask

   // sample and drive 2 ns after the edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
      cycle++;
      check_outputs();
   endtask

   task automatic idle_inputs();
      packet_valid = 1'b0;
      packet_in    = '0;
   endtask

   task automatic issue_row(input int r);
      logic [7:0]  opc;
      logic [3:0]  fld;
      logic [19:0] user;
      logic [63:0] addr;
      logic [63:0] src;
      logic [63:0] data;
      logic [63:0] rdata;
      logic [31:0] hi;
      logic [31:0] lo;
      int          idx;
      opc  = tbl_opc[r];
      fld  = tbl_fld[r];
      addr = tbl_addr[r];
      user = 20'h5a000 ^ r[19:0];                 // unique per row
      src  = 64'h00c0_0000_0000_0000 + (r << 4);
      data = tbl_data[r];
      if (tbl_rnd[r]) begin
         hi   = $random(seed);
         lo   = $random(seed);
         data = {hi, lo};
      end
      packet_in    = make_packet(opc, fld, user, addr, src, data);
      packet_valid = 1'b1;
      idx   = word_index(addr);
      rdata = '0; // acked writes return zero
      if (tbl_out[r] != out_err) begin
         case (opc)
            op_read: rdata = ref_mem[idx];
            op_post: ref_mem[idx] = data;
            op_ack:  ref_mem[idx] = data;
            op_amo: begin
               rdata        = ref_mem[idx]; // old value goes back
               ref_mem[idx] = atomic_result(fld, rdata, data);
            end
            default: ;
         endcase
      end
      if (tbl_out[r] == out_resp) begin
         n_expected++;
         exp_due.push_back(cycle + 2);
         exp_kind.push_back(out_resp);
         exp_pkt.push_back(make_packet((opc == op_ack) ? 8'h06 : 8'h07,
                                       (opc == op_amo) ? 4'd0 : fld, user, src, addr, rdata));
      end else if (tbl_out[r] == out_err) begin
         n_expected++;
         exp_due.push_back(cycle + 2);
         exp_kind.push_back(out_err);
         exp_pkt.push_back('0);
      end
   endtask

   task automatic drain_responses();
      int waited;
      waited = 0;
      while ((exp_due.size() > 0 || n_seen < n_expected) && waited < drain_limit) begin
         next_cycle();
         waited++;
      end
      if (n_seen < n_expected) begin
         error_count++;
         $display("timeout: no response arrived within %0d cycles", drain_limit);
      end
      n_seen = n_expected; // next test starts level
   endtask

   task automatic report_test(input string name, input int errs_at_start);
      if (error_count == errs_at_start) begin
         passed++;
         $display("test %s: ok", name);
      end else begin
         failed++;
         $display("test %s: %0d errors", name, error_count - errs_at_start);
      end
   endtask

   task automatic run_test(input int id, input string name);
      int errs_at_start;
      int r;
      errs_at_start = error_count;
      for (r = 0; r < n_rows; r++) begin
         if (tbl_test[r] == id) begin
            next_cycle();
            issue_row(r);
            if (tbl_gap[r]) begin
               next_cycle();
               idle_inputs();
            end
         end
      end
      next_cycle();
      idle_inputs();
      drain_responses();
      report_test(name, errs_at_start);
   endtask

   initial begin
      rst          = 1'b1;
      packet_valid = 1'b0;
      packet_in    = '0;
      seed         = 32'h428ab408;
      cycle        = 0;
      error_count  = 0;
      passed       = 0;
      failed       = 0;
      n_expected   = 0;
      n_seen       = 0;
      build_table();

      // outputs must stay quiet through reset and before any request
      errs_before = error_count;
      for (i = 0; i < 10; i++) begin
         next_cycle();
      end
      rst = 1'b0;
      for (i = 0; i < 3; i++) begin
         next_cycle();
      end
      report_test("reset state", errs_before);

      run_test(1, "write then read");
      run_test(2, "acknowledged write");
      run_test(3, "atomic operations");
      run_test(4, "back-to-back hazards");
      run_test(5, "invalid commands");

      $display("tests %0d, passed %0d, failed %0d, errors %0d", passed + failed, passed,
               failed, error_count);
      if (error_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
umi_pkg.sv
umi_agent_pkg.sv
umi_cmd_if.sv
umi_decode.sv
umi_unpack.sv
umi_pack.sv
umi_atomic_alu.sv
umi_mem_array.sv
umi_mem_agent_ctrl.sv
umi_mem_agent.sv
tb_umi_mem_agent.sv

// File: Bender.yml
package:
  name: umi_mem_agent

sources:
  - umi_pkg.sv
  - umi_agent_pkg.sv
  - umi_cmd_if.sv
  - umi_decode.sv
  - umi_unpack.sv
  - umi_pack.sv
  - umi_atomic_alu.sv
  - umi_mem_array.sv
  - umi_mem_agent_ctrl.sv
  - umi_mem_agent.sv
  - target: test
    files:
      - tb_umi_mem_agent.sv
